//--- project.f
+incdir+rtl
rtl/video_pkg.sv
rtl/raster_pkg.sv
rtl/dc_capture.sv
rtl/video2ram.sv
rtl/video_buffer.sv
rtl/flag_cross_domain.sv
rtl/startup_delay.sv
rtl/ram2video.sv
rtl/dcx_top.sv
testbench/tb_dcx.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_dcx &&
./obj_dir/Vtb_dcx | awk '{ print } /^TB PASSED$/ { found = 1 } END { exit !found }' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- testbench/tb_dcx.sv
`timescale 1ns/1ps
`include "dcx_settings.svh"

module tb_dcx;
    import video_pkg::*;

    // input raster of the stimulus, in pixel times and lines.
    localparam int IN_H_TOTAL       = 40;
    localparam int IN_V_TOTAL       = 20;
    localparam int IN_HSYNC_HALVES  = 6;
    localparam int IN_VSYNC_LINES   = 2;
    localparam int FRAMES           = 5;
    localparam int IN_FRAME_CYCLES  = IN_H_TOTAL * IN_V_TOTAL * 2;
    localparam int TIMEOUT_CYCLES   = 6 * IN_FRAME_CYCLES;
    localparam int OUT_FRAME_CYCLES = `DCX_OUT_H_TOTAL * `DCX_OUT_V_TOTAL;
    localparam int LAST_ROW         = `DCX_IN_V_START + `DCX_ACTIVE_H - 1;
    localparam int LAST_HALF        = 2 * (`DCX_IN_H_START + `DCX_ACTIVE_W) - 1;

    logic       clock54    = 1'b0;
    logic       hdmi_clock = 1'b0;
    logic       rst;
    logic       _hsync;
    logic       _vsync;
    half_word_t data;
    logic       hsync;
    logic       vsync;
    logic       de;
    rgb_t       video;
    logic       ready;

    logic [31:0] lcg_state;
    logic [31:0] frame_seeds [$];
    int          mismatches  = 0;
    int          failures    = 0;
    int          frames_out  = 0;
    int          frame_pos   = 0;
    int          cycle_count = 0;
    bit          in_frame    = 1'b0;
    bit          ready_seen  = 1'b0;

    always #2 clock54 = ~clock54;
    always #3 hdmi_clock = ~hdmi_clock;

    dcx_top dut_i (
        .clock54    (clock54),
        .hdmi_clock (hdmi_clock),
        .rst        (rst),
        ._hsync     (_hsync),
        ._vsync     (_vsync),
        .data       (data),
        .hsync      (hsync),
        .vsync      (vsync),
        .de         (de),
        .video      (video),
        .ready      (ready)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // pixel colour from frame seed and window position.
    function automatic rgb_t expected_pixel(input logic [31:0] seed, input int col,
                                            input int row);
        logic [31:0] mix;
        mix = seed ^ (32'(row) << 16) ^ 32'(col);
        mix = mix * 32'h9e37_79b1;
        mix = mix ^ (mix >> 15);
        return rgb_t'(mix[23:0]);
    endfunction

    task automatic compare_value(input string name, input logic [23:0] got,
                                 input logic [23:0] expected);
        assert (got === expected) else begin
            mismatches++;
            $display("Mismatch at %0t ns: %s expected %h got %h", $time, name, expected, got);
        end
    endtask

    // ************************************************************************
    // stimulus, two half-pixels per pixel time.
    // ************************************************************************
    task automatic drive_frame(input logic [31:0] seed);
        rgb_t word;
        for (int row = 0; row < IN_V_TOTAL; row++) begin
            for (int half = 0; half < 2 * IN_H_TOTAL; half++) begin
                word = expected_pixel(seed, half / 2 - `DCX_IN_H_START,
                                      row - `DCX_IN_V_START);
                @(posedge clock54);
                _hsync <= (half >= IN_HSYNC_HALVES);
                _vsync <= (row >= IN_VSYNC_LINES);
                data   <= (half % 2 == 0) ? word[23:12] : word[11:0];
                // only frames finished after ready can reach the output.
                if (row == LAST_ROW && half == LAST_HALF && ready) begin
                    frame_seeds.push_back(seed);
                end
            end
        end
    endtask

    initial begin
        rst    = 1'b1;
        _hsync = 1'b1;
        _vsync = 1'b1;
        data   = '0;
        repeat (4) @(posedge clock54);
        rst <= 1'b0;
        @(negedge hdmi_clock);
        compare_value("hsync", 24'(hsync), 24'd0);
        compare_value("vsync", 24'(vsync), 24'd0);
        compare_value("de", 24'(de), 24'd0);
        compare_value("ready", 24'(ready), 24'd0);
        compare_value("video", video, 24'd0);
        lcg_state = 32'hb802_68ab;
        for (int f = 0; f < FRAMES; f++) begin
            lcg_state = lcg_next(lcg_state);
            drive_frame(lcg_state);
        end
        while (frames_out < frame_seeds.size() || in_frame) begin
            @(posedge clock54);
        end
        assert (frame_seeds.size() > 0) else begin
            failures++;
            $display("no input frame completed after ready rose");
        end
        assert (frames_out == frame_seeds.size()) else begin
            failures++;
            $display("expected %0d output frames but saw %0d", frame_seeds.size(), frames_out);
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // ************************************************************************
    // output checker, position counted from the rise of de.
    // ************************************************************************
    always @(negedge hdmi_clock) begin : check_raster
        int col;
        int row;
        bit exp_de;
        bit exp_hs;
        bit exp_vs;
        if (!rst) begin
            if (ready_seen) begin
                assert (ready) else begin
                    failures++;
                    $display("ready fell at %0t ns after it had risen", $time);
                end
            end
            if (ready) begin
                ready_seen = 1'b1;
            end
            if (!in_frame && de) begin
                assert (frames_out < frame_seeds.size()) else begin
                    failures++;
                    $display("output frame started at %0t ns with no input frame ready", $time);
                end
                in_frame  = 1'b1;
                frame_pos = 0;
            end
            if (in_frame) begin
                col    = frame_pos % `DCX_OUT_H_TOTAL;
                row    = frame_pos / `DCX_OUT_H_TOTAL;
                exp_de = (row < `DCX_ACTIVE_H) && (col < `DCX_ACTIVE_W);
                exp_hs = (col >= `DCX_OUT_HSYNC_START) &&
                         (col < `DCX_OUT_HSYNC_START + `DCX_OUT_HSYNC_LEN);
                exp_vs = (row >= `DCX_OUT_VSYNC_START) &&
                         (row < `DCX_OUT_VSYNC_START + `DCX_OUT_VSYNC_LEN);
                compare_value("de", 24'(de), 24'(exp_de));
                compare_value("hsync", 24'(hsync), 24'(exp_hs));
                compare_value("vsync", 24'(vsync), 24'(exp_vs));
                if (exp_de && frames_out < frame_seeds.size()) begin
                    compare_value("video", video,
                                  expected_pixel(frame_seeds[frames_out], col, row));
                end
                frame_pos++;
                if (frame_pos == OUT_FRAME_CYCLES) begin
                    in_frame = 1'b0;
                    frames_out++;
                end
            end else begin
                assert (!de && !hsync && !vsync) else begin
                    failures++;
                    $display("sync or de active between output frames at %0t ns", $time);
                end
            end
        end
    end

    // run limit, six input frames of clock54 cycles.
    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock54);
            cycle_count++;
        end
        failures++;
        $display("timeout after %0d clock54 cycles, %0d output frames seen",
                 cycle_count, frames_out);
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- rtl/dcx_top.sv
`timescale 1ns/1ps
`include "dcx_settings.svh"

module dcx_top (
    input  logic                  clock54,
    input  logic                  hdmi_clock,
    input  logic                  rst,
    input  logic                  _hsync,
    input  logic                  _vsync,
    input  video_pkg::half_word_t data,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  de,
    output video_pkg::rgb_t       video,
    output logic                  ready
);
    import video_pkg::*;
    import raster_pkg::*;

    logic                             pixel_valid;
    pixel_word_t                      pixel;
    column_t                          pixel_x;
    line_t                            pixel_y;
    logic                             ram_wren;
    logic [`DCX_RAM_ADDRESS_BITS-1:0] ram_wraddress;
    rgb_t                             ram_wrdata;
    logic [`DCX_RAM_ADDRESS_BITS-1:0] ram_rdaddress;
    rgb_t                             ram_rddata;
    logic                             frame_ready;
    logic                             output_trigger;
    logic                             output_ready;

    assign ready = output_ready;

    // ***********************************************************************
    // console side, clock54.
    // ***********************************************************************
    dc_capture video_input (
        .clock       (clock54),
        .rst         (rst),
        ._hsync      (_hsync),
        ._vsync      (_vsync),
        .data        (data),
        .pixel_valid (pixel_valid),
        .pixel       (pixel),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y)
    );

    video2ram video2ram (
        .clock       (clock54),
        .rst         (rst),
        .pixel_valid (pixel_valid),
        .pixel       (pixel),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .wren        (ram_wren),
        .wraddress   (ram_wraddress),
        .wrdata      (ram_wrdata),
        .frame_ready (frame_ready)
    );

    // ***********************************************************************
    // clock domain crossing.
    // ***********************************************************************
    video_buffer video_buffer (
        .wrclock   (clock54),
        .wren      (ram_wren),
        .wraddress (ram_wraddress),
        .data      (ram_wrdata),
        .rdclock   (hdmi_clock),
        .rdaddress (ram_rdaddress),
        .q         (ram_rddata)
    );

    flag_cross_domain trigger (
        .clock_a  (clock54),
        .flag_in  (frame_ready),
        .clock_b  (hdmi_clock),
        .flag_out (output_trigger)
    );

    // ***********************************************************************
    // hdmi side.
    // ***********************************************************************
    startup_delay ram2video_startup_delay (
        .clock (hdmi_clock),
        .rst   (rst),
        .ready (output_ready)
    );

    ram2video ram2video (
        .clock  (hdmi_clock),
        .rst    (rst),
        .start  (output_trigger),
        .enable (output_ready),
        .rddata (ram_rddata),
        .rdaddr (ram_rdaddress),
        .hsync  (hsync),
        .vsync  (vsync),
        .de     (de),
        .video  (video)
    );

endmodule

//--- rtl/ram2video.sv
`timescale 1ns/1ps
`include "dcx_settings.svh"

module ram2video (
    input  logic                             clock,
    input  logic                             rst,
    input  logic                             start,
    input  logic                             enable,
    input  video_pkg::rgb_t                  rddata,
    output logic [`DCX_RAM_ADDRESS_BITS-1:0] rdaddr,
    output logic                             hsync,
    output logic                             vsync,
    output logic                             de,
    output video_pkg::rgb_t                  video
);
    import raster_pkg::*;

    localparam int      ADDR_W   = `DCX_RAM_ADDRESS_BITS;
    localparam int      ACT_W    = `DCX_ACTIVE_W;
    localparam column_t H_ACTIVE = column_t'(`DCX_ACTIVE_W);
    localparam line_t   V_ACTIVE = line_t'(`DCX_ACTIVE_H);
    localparam column_t H_LAST   = column_t'(`DCX_OUT_H_TOTAL - 1);
    localparam line_t   V_LAST   = line_t'(`DCX_OUT_V_TOTAL - 1);
    localparam column_t HS_FIRST = column_t'(`DCX_OUT_HSYNC_START);
    localparam column_t HS_END   = column_t'(`DCX_OUT_HSYNC_START + `DCX_OUT_HSYNC_LEN);
    localparam line_t   VS_FIRST = line_t'(`DCX_OUT_VSYNC_START);
    localparam line_t   VS_END   = line_t'(`DCX_OUT_VSYNC_START + `DCX_OUT_VSYNC_LEN);

    logic    running;
    column_t h_count;
    line_t   v_count;
    logic    active;
    logic    hs_now;
    logic    vs_now;
    logic    de_d;
    logic    hsync_d;
    logic    vsync_d;

    assign active = running && (h_count < H_ACTIVE) && (v_count < V_ACTIVE);
    assign hs_now = running && (h_count >= HS_FIRST) && (h_count < HS_END);
    assign vs_now = running && (v_count >= VS_FIRST) && (v_count < VS_END);

    // ***********************************************************************
    // raster scan, one frame per accepted start.
    // ***********************************************************************
    always_ff @(posedge clock) begin
        if (rst) begin
            running <= 1'b0;
            h_count <= '0;
            v_count <= '0;
        end else if (running) begin
            if (h_count == H_LAST) begin
                h_count <= '0;
                if (v_count == V_LAST) begin
                    v_count <= '0;
                    running <= 1'b0;
                end else begin
                    v_count <= v_count + 1'b1;
                end
            end else begin
                h_count <= h_count + 1'b1;
            end
        end else if (start && enable) begin
            running <= 1'b1;
            h_count <= '0;
            v_count <= '0;
        end
    end

    // ***********************************************************************
    // address stage, then buffer read stage.
    // ***********************************************************************
    always_ff @(posedge clock) begin
        rdaddr <= ADDR_W'(v_count * ACT_W + h_count);
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            de_d    <= 1'b0;
            hsync_d <= 1'b0;
            vsync_d <= 1'b0;
            de      <= 1'b0;
            hsync   <= 1'b0;
            vsync   <= 1'b0;
        end else begin
            de_d    <= active;
            hsync_d <= hs_now;
            vsync_d <= vs_now;
            de      <= de_d;
            hsync   <= hsync_d;
            vsync   <= vsync_d;
        end
    end

    // black outside the active area.
    assign video = de ? rddata : '0;

    assert property (@(posedge clock) disable iff (rst) running |-> !start);

endmodule

//--- rtl/startup_delay.sv
`timescale 1ns/1ps
`include "dcx_settings.svh"

module startup_delay (
    input  logic clock,
    input  logic rst,
    output logic ready
);
    localparam int CYCLES  = `DCX_STARTUP_CYCLES;
    localparam int COUNT_W = $clog2(CYCLES);

    logic [COUNT_W-1:0] count;

    always_ff @(posedge clock) begin
        if (rst) begin
            count <= '0;
            ready <= 1'b0;
        end else if (!ready) begin
            count <= count + 1'b1;
            if (count == COUNT_W'(CYCLES - 1)) begin
                ready <= 1'b1;
            end
        end
    end

endmodule

//--- rtl/flag_cross_domain.sv
`timescale 1ns/1ps

module flag_cross_domain (
    input  logic clock_a,
    input  logic flag_in,
    input  logic clock_b,
    output logic flag_out
);
    logic       toggle_a = 1'b0;
    logic [2:0] sync_b   = 3'b000;

    // each pulse flips the level.
    always_ff @(posedge clock_a) begin
        toggle_a <= toggle_a ^ flag_in;
    end

    always_ff @(posedge clock_b) begin
        sync_b <= {sync_b[1:0], toggle_a};
    end

    // level change back to a pulse.
    assign flag_out = sync_b[2] ^ sync_b[1];

    // pulses closer than this could merge in the slower domain.
    assert property (@(posedge clock_a) flag_in |=> !flag_in [*3]);

endmodule

//--- rtl/video_buffer.sv
`timescale 1ns/1ps
`include "dcx_settings.svh"

module video_buffer (
    input  logic                             wrclock,
    input  logic                             wren,
    input  logic [`DCX_RAM_ADDRESS_BITS-1:0] wraddress,
    input  video_pkg::rgb_t                  data,
    input  logic                             rdclock,
    input  logic [`DCX_RAM_ADDRESS_BITS-1:0] rdaddress,
    output video_pkg::rgb_t                  q
);
    import video_pkg::*;

    localparam int DEPTH = 2 ** `DCX_RAM_ADDRESS_BITS;

    rgb_t mem [0:DEPTH-1];

    always_ff @(posedge wrclock) begin
        if (wren) begin
            mem[wraddress] <= data;
        end
    end

    // registered read on the output side.
    always_ff @(posedge rdclock) begin
        q <= mem[rdaddress];
    end

    assert property (@(posedge wrclock) wren |-> !$isunknown(data));

endmodule

//--- rtl/video2ram.sv
`timescale 1ns/1ps
`include "dcx_settings.svh"

module video2ram (
    input  logic                             clock,
    input  logic                             rst,
    input  logic                             pixel_valid,
    input  video_pkg::pixel_word_t           pixel,
    input  raster_pkg::column_t              pixel_x,
    input  raster_pkg::line_t                pixel_y,
    output logic                             wren,
    output logic [`DCX_RAM_ADDRESS_BITS-1:0] wraddress,
    output video_pkg::rgb_t                  wrdata,
    output logic                             frame_ready
);
    import raster_pkg::*;

    localparam int      ADDR_W   = `DCX_RAM_ADDRESS_BITS;
    localparam int      ACT_W    = `DCX_ACTIVE_W;
    localparam column_t LAST_COL = column_t'(`DCX_ACTIVE_W - 1);
    localparam line_t   LAST_ROW = line_t'(`DCX_ACTIVE_H - 1);

    logic last_pixel;

    assign last_pixel = (pixel_x == LAST_COL) && (pixel_y == LAST_ROW);

    // trigger goes out with the write of the last pixel.
    always_ff @(posedge clock) begin
        if (rst) begin
            wren        <= 1'b0;
            frame_ready <= 1'b0;
        end else begin
            wren        <= pixel_valid;
            frame_ready <= pixel_valid && last_pixel;
        end
    end

    // row-major address.
    always_ff @(posedge clock) begin
        if (pixel_valid) begin
            wraddress <= ADDR_W'(pixel_y * ACT_W + pixel_x);
            wrdata    <= pixel.rgb;
        end
    end

endmodule

//--- rtl/dc_capture.sv
`timescale 1ns/1ps
`include "dcx_settings.svh"

module dc_capture (
    input  logic                   clock,
    input  logic                   rst,
    input  logic                   _hsync,
    input  logic                   _vsync,
    input  video_pkg::half_word_t  data,
    output logic                   pixel_valid,
    output video_pkg::pixel_word_t pixel,
    output raster_pkg::column_t    pixel_x,
    output raster_pkg::line_t      pixel_y
);
    import video_pkg::*;
    import raster_pkg::*;

    localparam column_t H_FIRST = column_t'(`DCX_IN_H_START);
    localparam column_t H_END   = column_t'(`DCX_IN_H_START + `DCX_ACTIVE_W);
    localparam line_t   V_FIRST = line_t'(`DCX_IN_V_START);
    localparam line_t   V_END   = line_t'(`DCX_IN_V_START + `DCX_ACTIVE_H);

    logic       hsync_prev;
    logic       vsync_prev;
    logic       frame_pending;
    logic       second_half;
    half_word_t first_half;
    column_t    h_count;
    line_t      v_count;
    logic       hsync_fall;
    logic       vsync_fall;
    logic       in_window;

    assign hsync_fall = hsync_prev & ~_hsync;
    assign vsync_fall = vsync_prev & ~_vsync;
    assign in_window  = (h_count >= H_FIRST) && (h_count < H_END) &&
                        (v_count >= V_FIRST) && (v_count < V_END);

    // sync edges and line count.
    always_ff @(posedge clock) begin
        if (rst) begin
            hsync_prev    <= 1'b1;
            vsync_prev    <= 1'b1;
            frame_pending <= 1'b0;
            v_count       <= '1;
        end else begin
            hsync_prev <= _hsync;
            vsync_prev <= _vsync;
            if (hsync_fall) begin
                frame_pending <= 1'b0;
                if (frame_pending || vsync_fall) begin
                    v_count <= '0;
                end else if (v_count != '1) begin
                    v_count <= v_count + 1'b1;
                end
            end else if (vsync_fall) begin
                frame_pending <= 1'b1;
            end
        end
    end

    // half phase restarts on every hsync fall.
    always_ff @(posedge clock) begin
        if (rst) begin
            second_half <= 1'b0;
            h_count     <= '1;
            pixel_valid <= 1'b0;
        end else begin
            pixel_valid <= 1'b0;
            if (hsync_fall) begin
                second_half <= 1'b1;
                h_count     <= '0;
            end else begin
                second_half <= ~second_half;
                if (second_half) begin
                    pixel_valid <= in_window;
                    if (h_count != '1) begin
                        h_count <= h_count + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (hsync_fall || !second_half) begin
            first_half <= data;
        end else begin
            pixel.halves.first  <= first_half;
            pixel.halves.second <= data;
            pixel_x             <= h_count - H_FIRST;
            pixel_y             <= v_count - V_FIRST;
        end
    end

    // a line holds a whole number of pixels.
    assert property (@(posedge clock) disable iff (rst)
        hsync_fall && (h_count != '1) |-> !second_half);

endmodule

//--- rtl/raster_pkg.sv
package raster_pkg;

    // raster positions, 12 bits like the console counters.
    typedef logic [11:0] column_t;
    typedef logic [11:0] line_t;

endpackage

//--- rtl/video_pkg.sv
package video_pkg;

    // one half-pixel as driven by the console.
    typedef logic [11:0] half_word_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // halves in arrival order.
    typedef struct packed {
        half_word_t first;
        half_word_t second;
    } half_pair_t;

    // same 24 bits, as the input pair or as colours.
    typedef union packed {
        half_pair_t halves;
        rgb_t       rgb;
    } pixel_word_t;

endpackage

//--- rtl/dcx_settings.svh
`ifndef DCX_SETTINGS_SVH
`define DCX_SETTINGS_SVH

// active frame, pixels by lines.
`define DCX_ACTIVE_W 32
`define DCX_ACTIVE_H 16

// first active pixel and line, counted from the sync falling edges.
`define DCX_IN_H_START 4
`define DCX_IN_V_START 2

// output raster, active lines first and blanking after.
`define DCX_OUT_H_TOTAL 40
`define DCX_OUT_HSYNC_START 34
`define DCX_OUT_HSYNC_LEN 3
`define DCX_OUT_V_TOTAL 20
`define DCX_OUT_VSYNC_START 17
`define DCX_OUT_VSYNC_LEN 2

`define DCX_RAM_ADDRESS_BITS 9
`define DCX_STARTUP_CYCLES 64

`endif
